// ==== Makefile ====
SIM = obj_dir/VmipsTb

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module mipsTb -Mdir obj_dir -f compile.f

run: compile
	./$(SIM) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// ==== compile.f ====
+incdir+dv
src/mipsPkg.sv
src/fetchStage.sv
src/registerFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/hazardUnit.sv
src/mipsCore.sv
dv/mipsTb.sv

// ==== dv/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Register-type word with shamt always zero
function automatic logic [31:0] encR(input logic [5:0] fn, input int rs, input int rt,
		input int rd);
	return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
endfunction

function automatic logic [31:0] encI(input logic [5:0] op, input int rs, input int rt,
		input int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic int rnd(input int n);
	return int'($unsigned($random(seed)) % n);
endfunction

// Random body over r1..r7 followed by the register dump and a self loop
task automatic genProgram(input bit useMem, input bit useBranch, input bit depBias);
	int kind;
	int rd;
	int rs;
	int rt;
	int maxOff;
	int lastDest;
	bit inSlot;
	lastDest = 1;
	inSlot = 1'b0;
	for (int a = 0; a < 1024; a++) begin
		imem[a] = '0;
	end
	for (int i = 0; i < NumRandom; i++) begin
		kind = rnd(10);
		rd = 1 + rnd(7);
		rs = (depBias && rnd(2) == 0) ? lastDest : 1 + rnd(7);
		rt = 1 + rnd(7);
		maxOff = (NumRandom - 1 - i > 3) ? 3 : NumRandom - 1 - i;
		if (kind == 8 && !useMem) kind = 0;
		// No branch in a delay slot and no target past the body
		if (kind == 9 && (!useBranch || inSlot || maxOff < 1)) kind = 3;
		inSlot = kind == 9;
		case (kind)
			0: imem[i] = encR(mipsPkg::FnAddu, rs, rt, rd);
			1: imem[i] = encR(mipsPkg::FnSubu, rs, rt, rd);
			2: imem[i] = encR(mipsPkg::FnAnd, rs, rt, rd);
			3: imem[i] = encR(mipsPkg::FnOr, rs, rt, rd);
			4: imem[i] = encR(mipsPkg::FnSlt, rs, rt, rd);
			5: imem[i] = encI(mipsPkg::OpAddiu, rs, rd, rnd(65536));
			6: imem[i] = encI(mipsPkg::OpOri, rs, rd, rnd(65536));
			7: imem[i] = encI(mipsPkg::OpLui, 0, rd, rnd(65536));
			8: begin
				if (rnd(2) == 0) begin
					imem[i] = encI(mipsPkg::OpLw, 0, rd, 4 * rnd(16));
				end else begin
					imem[i] = encI(mipsPkg::OpSw, 0, rs, 4 * rnd(16));
					rd = lastDest;
				end
			end
			// Half of the branches compare a register with itself and are taken
			default: begin
				imem[i] = encI(mipsPkg::OpBeq, rs, rnd(2) == 0 ? rs : rt, 1 + rnd(maxOff));
				rd = lastDest;
			end
		endcase
		lastDest = rd;
	end
	for (int r = 1; r < 8; r++) begin
		imem[NumRandom + r - 1] = encI(mipsPkg::OpSw, 0, r, 4 * (63 + r));
	end
	// r0 takes a nonzero write and must still be stored as zero
	imem[NumRandom + 7] = encI(mipsPkg::OpOri, 0, 0, 1 + rnd(65535));
	imem[NumRandom + 8] = encI(mipsPkg::OpSw, 0, 0, 4 * 71);
	imem[HaltIdx] = encI(mipsPkg::OpBeq, 0, 0, -1);
endtask

// Architectural interpreter with delay slots that records every store in order
task automatic runModel();
	logic [31:0] rf [32];
	logic [31:0] mem [1024];
	logic [31:0] ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm;
	logic [31:0] res;
	logic [4:0] dst;
	int pc;
	int npc;
	int nxt;
	for (int k = 0; k < 32; k++) begin
		rf[k] = '0;
	end
	for (int k = 0; k < 1024; k++) begin
		mem[k] = fillWord(k);
	end
	expAddr.delete();
	expData.delete();
	pc = 0;
	npc = 1;
	while (pc != HaltIdx) begin
		ins = imem[pc];
		a = rf[ins[25:21]];
		b = rf[ins[20:16]];
		imm = {{16{ins[15]}}, ins[15:0]};
		nxt = npc + 1;
		dst = '0;
		res = '0;
		case (ins[31:26])
			mipsPkg::OpSpecial: begin
				dst = ins[15:11];
				case (ins[5:0])
					mipsPkg::FnAddu: res = a + b;
					mipsPkg::FnSubu: res = a - b;
					mipsPkg::FnAnd: res = a & b;
					mipsPkg::FnOr: res = a | b;
					mipsPkg::FnSlt: res = {31'b0, $signed(a) < $signed(b)};
					default: dst = '0;
				endcase
			end
			mipsPkg::OpAddiu: begin
				dst = ins[20:16];
				res = a + imm;
			end
			mipsPkg::OpOri: begin
				dst = ins[20:16];
				res = a | {16'b0, ins[15:0]};
			end
			mipsPkg::OpLui: begin
				dst = ins[20:16];
				res = {ins[15:0], 16'b0};
			end
			mipsPkg::OpLw: begin
				dst = ins[20:16];
				res = a + imm;
				res = mem[res[11:2]];
			end
			mipsPkg::OpSw: begin
				res = a + imm;
				mem[res[11:2]] = b;
				expAddr.push_back(res[11:2]);
				expData.push_back(b);
			end
			mipsPkg::OpBeq: begin
				if (a == b) nxt = pc + 1 + int'($signed(ins[15:0]));
			end
			default: dst = '0;
		endcase
		if (dst != '0) rf[dst] = res;
		pc = npc;
		npc = nxt;
	end
endtask

`endif

// ==== dv/mipsTb.sv ====
`timescale 1ns/1ns

module mipsTb;

	localparam int NumRuns = 6;
	localparam int NumRandom = 30;
	localparam int HaltIdx = NumRandom + 9;
	localparam int ProgLen = NumRandom + 11;

	logic clk;
	logic rst;
	logic [9:0] imAddr;
	logic [31:0] imData;
	logic [9:0] dmAddr;
	logic [31:0] dmWData;
	logic dmWe;
	logic [31:0] dmRData;
	logic [31:0] imem [1024];
	logic [31:0] dmem [1024];
	logic loadMem;
	integer seed;
	int runIdx;
	int errors;
	int passed;
	logic [9:0] expAddr [$];
	logic [31:0] expData [$];

	// Odd multiplier spreads every address bit and the run number changes the data
	function automatic logic [31:0] fillWord(input int a);
		return (32'(a) * 32'h9e37_79b1) ^ (32'(runIdx) << 24);
	endfunction

	`include "isaModel.svh"

	mipsCore i_mipsCore (
		.clk(clk),
		.rst(rst),
		.imAddr(imAddr),
		.imData(imData),
		.dmAddr(dmAddr),
		.dmWData(dmWData),
		.dmWe(dmWe),
		.dmRData(dmRData)
	);

	// Both memories answer in the same cycle
	assign imData = imem[imAddr];
	assign dmRData = dmem[dmAddr];

	always @(posedge clk) begin
		if (loadMem) begin
			for (int a = 0; a < 1024; a++) begin
				dmem[a] <= fillWord(a);
			end
		end else if (dmWe) begin
			dmem[dmAddr] <= dmWData;
		end
	end

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic doRun(input string name, input bit useMem, input bit useBranch,
			input bit depBias, input bit midReset);
		int got;
		int cycles;
		int runErr;
		got = 0;
		cycles = 0;
		runErr = 0;
		runIdx++;
		@(negedge clk);
		rst = 1'b1;
		loadMem = 1'b1;
		genProgram(useMem, useBranch, depBias);
		runModel();
		if (midReset) begin
			// Start the program and reset it again while its first store is in memory
			repeat (10) begin
				@(negedge clk);
			end
			rst = 1'b0;
			loadMem = 1'b0;
			while (dmWe !== 1'b1 && cycles < 4 * ProgLen + 40) begin
				@(negedge clk);
				cycles++;
			end
			if (dmWe !== 1'b1) begin
				$display("%s: no store reached memory before the second reset", name);
				runErr++;
			end
			rst = 1'b1;
			loadMem = 1'b1;
			cycles = 0;
		end
		repeat (10) begin
			@(negedge clk);
			if (dmWe !== 1'b0) begin
				$display("%s: dmWe was not low during reset", name);
				runErr++;
			end
		end
		rst = 1'b0;
		loadMem = 1'b0;
		while (got < expAddr.size() && cycles < 4 * ProgLen + 40) begin
			@(negedge clk);
			cycles++;
			if (dmWe === 1'b1) begin
				if (dmAddr !== expAddr[got] || dmWData !== expData[got]) begin
					$display("FAIL %s store %0d expected %h:%h actual %h:%h", name, got,
						expAddr[got], expData[got], dmAddr, dmWData);
					runErr++;
				end
				got++;
			end
		end
		if (got < expAddr.size()) begin
			$display("%s: only %0d of %0d stores arrived in time", name, got, expAddr.size());
			runErr++;
		end
		// Core now spins on the final loop and must stay quiet
		repeat (8) begin
			@(negedge clk);
			if (dmWe === 1'b1) begin
				$display("%s: store to %h after the program ended", name, dmAddr);
				runErr++;
			end
		end
		errors += runErr;
		if (runErr == 0) passed++;
		$display("%s: %s, %0d stores", name, runErr == 0 ? "ok" : "failed", got);
	endtask

	initial begin
		seed = 21691;
		rst = 1'b1;
		loadMem = 1'b1;
		runIdx = 0;
		errors = 0;
		passed = 0;
		doRun("straight ALU code", 1'b0, 1'b0, 1'b0, 1'b0);
		doRun("back-to-back dependences", 1'b0, 1'b0, 1'b1, 1'b0);
		doRun("load then use", 1'b1, 1'b0, 1'b1, 1'b0);
		doRun("branches with delay slot", 1'b1, 1'b1, 1'b1, 1'b0);
		doRun("store sequence", 1'b1, 1'b1, 1'b0, 1'b0);
		doRun("reset", 1'b1, 1'b1, 1'b1, 1'b1);
		$display("%0d of %0d tests passed, %0d errors", passed, NumRuns, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog sized from the reset, program and drain cycles of every run
	initial begin
		#(NumRuns * (10 + 4 * ProgLen + 60) * 8);
		$display("Watchdog expired, the core stopped making progress");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== src/decodeStage.sv ====
`timescale 1ns/1ns

module decodeStage (
	input logic clk,
	input logic rst,
	input logic stall,
	input mipsPkg::ifIdT ifId,
	input mipsPkg::wordT rsVal,
	input mipsPkg::wordT rtVal,
	input mipsPkg::fwdSelE fwdCmpA,
	input mipsPkg::fwdSelE fwdCmpB,
	input mipsPkg::wordT memFwd,
	input mipsPkg::wordT wbFwd,
	output mipsPkg::regAddrT rs,
	output mipsPkg::regAddrT rt,
	output logic branchTaken,
	output mipsPkg::wordT branchTarget,
	output mipsPkg::idExT idEx
);

	mipsPkg::opcodeE op;
	mipsPkg::functE fn;
	mipsPkg::ctrlT ctrl;
	mipsPkg::regAddrT dest;
	mipsPkg::wordT signImm;
	mipsPkg::wordT imm;
	mipsPkg::wordT cmpA;
	mipsPkg::wordT cmpB;

	assign op = mipsPkg::opcodeE'(ifId.instr[31:26]);
	assign fn = mipsPkg::functE'(ifId.instr[5:0]);

	always_comb begin
		ctrl = '0;
		dest = '0;
		case (op)
			mipsPkg::OpSpecial: begin
				ctrl.regWrite = 1'b1;
				dest = ifId.instr[15:11];
				case (fn)
					mipsPkg::FnAddu: ctrl.aluOp = mipsPkg::AluAdd;
					mipsPkg::FnSubu: ctrl.aluOp = mipsPkg::AluSub;
					mipsPkg::FnAnd: ctrl.aluOp = mipsPkg::AluAnd;
					mipsPkg::FnOr: ctrl.aluOp = mipsPkg::AluOr;
					mipsPkg::FnSlt: ctrl.aluOp = mipsPkg::AluSlt;
					default: begin
						ctrl.regWrite = 1'b0;
						dest = '0;
					end
				endcase
			end
			mipsPkg::OpAddiu, mipsPkg::OpOri, mipsPkg::OpLui, mipsPkg::OpLw: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				dest = ifId.instr[20:16];
				if (op == mipsPkg::OpOri) begin
					ctrl.aluOp = mipsPkg::AluOr;
					ctrl.zeroExt = 1'b1;
				end
				if (op == mipsPkg::OpLui) ctrl.aluOp = mipsPkg::AluLui;
				if (op == mipsPkg::OpLw) ctrl.memRead = 1'b1;
			end
			mipsPkg::OpSw: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			// beq and unknown opcodes write nothing
			default: ctrl = '0;
		endcase
	end

	// Only report operands the instruction really reads, keeps stalls exact
	assign rs = (op == mipsPkg::OpLui) ? '0 : ifId.instr[25:21];
	assign rt = (op == mipsPkg::OpSpecial || op == mipsPkg::OpSw || op == mipsPkg::OpBeq) ?
		ifId.instr[20:16] : '0;

	assign signImm = {{16{ifId.instr[15]}}, ifId.instr[15:0]};
	assign imm = ctrl.zeroExt ? {16'b0, ifId.instr[15:0]} : signImm;

	// Branch compare
	assign cmpA = mipsPkg::fwdPick(fwdCmpA, rsVal, memFwd, wbFwd);
	assign cmpB = mipsPkg::fwdPick(fwdCmpB, rtVal, memFwd, wbFwd);
	assign branchTaken = (op == mipsPkg::OpBeq) && (cmpA == cmpB);
	assign branchTarget = ifId.pcPlus4 + {signImm[29:0], 2'b00};

	always_ff @(posedge clk) begin
		if (rst || stall) begin
			idEx <= '0;
		end else begin
			idEx.ctrl <= ctrl;
			idEx.rsVal <= rsVal;
			idEx.rtVal <= rtVal;
			idEx.imm <= imm;
			idEx.rs <= rs;
			idEx.rt <= rt;
			idEx.dest <= dest;
		end
	end

endmodule

// ==== src/executeStage.sv ====
`timescale 1ns/1ns

module executeStage (
	input logic clk,
	input logic rst,
	input mipsPkg::idExT idEx,
	input mipsPkg::fwdSelE fwdAluA,
	input mipsPkg::fwdSelE fwdAluB,
	input mipsPkg::wordT memFwd,
	input mipsPkg::wordT wbFwd,
	output mipsPkg::exMemT exMem
);

	mipsPkg::wordT opA;
	mipsPkg::wordT rtFwd;
	mipsPkg::wordT opB;
	mipsPkg::wordT aluOut;

	assign opA = mipsPkg::fwdPick(fwdAluA, idEx.rsVal, memFwd, wbFwd);
	// Forwarded rt is also the store data
	assign rtFwd = mipsPkg::fwdPick(fwdAluB, idEx.rtVal, memFwd, wbFwd);
	assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : rtFwd;

	always_comb begin
		case (idEx.ctrl.aluOp)
			mipsPkg::AluSub: aluOut = opA - opB;
			mipsPkg::AluAnd: aluOut = opA & opB;
			mipsPkg::AluOr: aluOut = opA | opB;
			mipsPkg::AluSlt: begin
				aluOut = {{(mipsPkg::DataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
			end
			// Immediate goes to the upper half
			mipsPkg::AluLui: aluOut = {opB[15:0], 16'b0};
			default: aluOut = opA + opB;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exMem <= '0;
		end else begin
			exMem.ctrl <= idEx.ctrl;
			exMem.aluOut <= aluOut;
			exMem.storeVal <= rtFwd;
			exMem.dest <= idEx.dest;
		end
	end

endmodule

// ==== src/fetchStage.sv ====
`timescale 1ns/1ns

module fetchStage (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic branchTaken,
	input mipsPkg::wordT branchTarget,
	input mipsPkg::wordT imData,
	output logic [mipsPkg::ImAddrWidth-1:0] imAddr,
	output mipsPkg::ifIdT ifId
);

	mipsPkg::wordT pc;
	mipsPkg::wordT pcPlus4;

	assign pcPlus4 = pc + 32'd4;
	// Word address into instruction memory
	assign imAddr = pc[mipsPkg::ImAddrWidth+1:2];

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (!stall) begin
			// Branch resolves in decode, the delay slot is already being fetched
			pc <= branchTaken ? branchTarget : pcPlus4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ifId <= '0;
		end else if (!stall) begin
			ifId.instr <= imData;
			ifId.pcPlus4 <= pcPlus4;
		end
	end

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ns

module hazardUnit (
	input mipsPkg::regAddrT rs,
	input mipsPkg::regAddrT rt,
	input mipsPkg::idExT idEx,
	input mipsPkg::exMemT exMem,
	input mipsPkg::memWbT memWb,
	input logic isBranch,
	output mipsPkg::fwdSelE fwdCmpA,
	output mipsPkg::fwdSelE fwdCmpB,
	output mipsPkg::fwdSelE fwdAluA,
	output mipsPkg::fwdSelE fwdAluB,
	output logic stall
);

	logic loadUse;
	logic branchExec;
	logic branchMem;

	// Memory stage wins over writeback, a load in memory has no data yet
	function automatic mipsPkg::fwdSelE pickSrc(input mipsPkg::regAddrT r,
			input mipsPkg::exMemT m, input mipsPkg::memWbT w);
		if (r != '0 && m.ctrl.regWrite && !m.ctrl.memRead && m.dest == r) begin
			return mipsPkg::FwdMem;
		end else if (r != '0 && w.regWrite && w.dest == r) begin
			return mipsPkg::FwdWb;
		end
		return mipsPkg::FwdReg;
	endfunction

	// Decode operands match a nonzero destination
	function automatic logic readsDest(input mipsPkg::regAddrT d,
			input mipsPkg::regAddrT a, input mipsPkg::regAddrT b);
		return d != '0 && (d == a || d == b);
	endfunction

	assign fwdCmpA = pickSrc(rs, exMem, memWb);
	assign fwdCmpB = pickSrc(rt, exMem, memWb);
	assign fwdAluA = pickSrc(idEx.rs, exMem, memWb);
	assign fwdAluB = pickSrc(idEx.rt, exMem, memWb);

	assign loadUse = idEx.ctrl.memRead && readsDest(idEx.dest, rs, rt);
	// beq waits for any result still in execute
	assign branchExec = isBranch && idEx.ctrl.regWrite && readsDest(idEx.dest, rs, rt);
	// and for a load that has only reached memory
	assign branchMem = isBranch && exMem.ctrl.memRead && readsDest(exMem.dest, rs, rt);

	assign stall = loadUse || branchExec || branchMem;

endmodule

// ==== src/memoryStage.sv ====
`timescale 1ns/1ns

module memoryStage (
	input logic clk,
	input logic rst,
	input mipsPkg::exMemT exMem,
	input mipsPkg::wordT dmRData,
	output logic [mipsPkg::DmAddrWidth-1:0] dmAddr,
	output mipsPkg::wordT dmWData,
	output logic dmWe,
	output mipsPkg::memWbT memWb,
	output mipsPkg::wordT wbData
);

	// Word-wide port, byte offset bits dropped
	assign dmAddr = exMem.aluOut[mipsPkg::DmAddrWidth+1:2];
	assign dmWData = exMem.storeVal;
	assign dmWe = exMem.ctrl.memWrite;

	always_ff @(posedge clk) begin
		if (rst) begin
			memWb <= '0;
		end else begin
			memWb.regWrite <= exMem.ctrl.regWrite;
			memWb.memRead <= exMem.ctrl.memRead;
			memWb.aluOut <= exMem.aluOut;
			memWb.loadVal <= dmRData;
			memWb.dest <= exMem.dest;
		end
	end

	// Writeback value, also forwarded back to decode and execute
	assign wbData = memWb.memRead ? memWb.loadVal : memWb.aluOut;

endmodule

// ==== src/mipsCore.sv ====
`timescale 1ns/1ns

module mipsCore (
	input logic clk,
	input logic rst,
	output logic [mipsPkg::ImAddrWidth-1:0] imAddr,
	input mipsPkg::wordT imData,
	output logic [mipsPkg::DmAddrWidth-1:0] dmAddr,
	output mipsPkg::wordT dmWData,
	output logic dmWe,
	input mipsPkg::wordT dmRData
);

	mipsPkg::ifIdT ifId;
	mipsPkg::idExT idEx;
	mipsPkg::exMemT exMem;
	mipsPkg::memWbT memWb;

	mipsPkg::regAddrT rs;
	mipsPkg::regAddrT rt;
	mipsPkg::wordT rsVal;
	mipsPkg::wordT rtVal;
	mipsPkg::wordT wbData;
	mipsPkg::wordT branchTarget;
	mipsPkg::fwdSelE fwdCmpA;
	mipsPkg::fwdSelE fwdCmpB;
	mipsPkg::fwdSelE fwdAluA;
	mipsPkg::fwdSelE fwdAluB;
	logic branchTaken;
	logic stall;
	logic isBranch;

	// beq sitting in decode
	assign isBranch = ifId.instr[31:26] == mipsPkg::OpBeq;

	fetchStage i_fetchStage (
		.clk, .rst, .stall, .branchTaken, .branchTarget, .imData,
		.imAddr, .ifId
	);

	registerFile i_registerFile (
		.clk, .rst, .rs, .rt,
		.wAddr(memWb.dest), .wData(wbData), .we(memWb.regWrite),
		.rsVal, .rtVal
	);

	decodeStage i_decodeStage (
		.clk, .rst, .stall, .ifId, .rsVal, .rtVal, .fwdCmpA, .fwdCmpB,
		.memFwd(exMem.aluOut), .wbFwd(wbData),
		.rs, .rt, .branchTaken, .branchTarget, .idEx
	);

	executeStage i_executeStage (
		.clk, .rst, .idEx, .fwdAluA, .fwdAluB,
		.memFwd(exMem.aluOut), .wbFwd(wbData),
		.exMem
	);

	memoryStage i_memoryStage (
		.clk, .rst, .exMem, .dmRData,
		.dmAddr, .dmWData, .dmWe, .memWb, .wbData
	);

	hazardUnit i_hazardUnit (
		.rs, .rt, .idEx, .exMem, .memWb, .isBranch,
		.fwdCmpA, .fwdCmpB, .fwdAluA, .fwdAluB, .stall
	);

endmodule

// ==== src/mipsPkg.sv ====
package mipsPkg;

	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int ImAddrWidth = 10;
	localparam int DmAddrWidth = 10;

	typedef logic [DataWidth-1:0] wordT;
	typedef logic [RegAddrWidth-1:0] regAddrT;

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		OpSpecial = 6'h00,
		OpBeq = 6'h04,
		OpAddiu = 6'h09,
		OpOri = 6'h0d,
		OpLui = 6'h0f,
		OpLw = 6'h23,
		OpSw = 6'h2b
	} opcodeE;

	// Function field of register-type instructions, instr[5:0]
	typedef enum logic [5:0] {
		FnAddu = 6'h21,
		FnSubu = 6'h23,
		FnAnd = 6'h24,
		FnOr = 6'h25,
		FnSlt = 6'h2a
	} functE;

	// AluAdd is zero so that a cleared control word is a harmless add
	typedef enum logic [2:0] {
		AluAdd = 3'd0,
		AluSub = 3'd1,
		AluAnd = 3'd2,
		AluOr = 3'd3,
		AluSlt = 3'd4,
		AluLui = 3'd5
	} aluOpE;

	// Operand source, register file value or a younger result in flight
	typedef enum logic [1:0] {
		FwdReg = 2'd0,
		FwdMem = 2'd1,
		FwdWb = 2'd2
	} fwdSelE;

	typedef struct packed {
		aluOpE aluOp;
		logic aluSrcImm;
		logic zeroExt;
		logic regWrite;
		logic memRead;
		logic memWrite;
	} ctrlT;

	typedef struct packed {
		wordT instr;
		wordT pcPlus4;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		wordT rsVal;
		wordT rtVal;
		wordT imm;
		regAddrT rs;
		regAddrT rt;
		regAddrT dest;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		wordT aluOut;
		wordT storeVal;
		regAddrT dest;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		wordT aluOut;
		wordT loadVal;
		regAddrT dest;
	} memWbT;

	// Forwarding mux shared by the branch compare and the ALU inputs
	function automatic wordT fwdPick(input fwdSelE sel, input wordT regVal,
			input wordT memVal, input wordT wbVal);
		case (sel)
			FwdMem: return memVal;
			FwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

endpackage

// ==== src/registerFile.sv ====
`timescale 1ns/1ns

module registerFile (
	input logic clk,
	input logic rst,
	input mipsPkg::regAddrT rs,
	input mipsPkg::regAddrT rt,
	input mipsPkg::regAddrT wAddr,
	input mipsPkg::wordT wData,
	input logic we,
	output mipsPkg::wordT rsVal,
	output mipsPkg::wordT rtVal
);

	mipsPkg::wordT regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wAddr != '0) begin
			regs[wAddr] <= wData;
		end
	end

	// Writeback value bypasses the array so decode sees it this cycle
	assign rsVal = (rs == '0) ? '0 : (we && wAddr == rs) ? wData : regs[rs];
	assign rtVal = (rt == '0) ? '0 : (we && wAddr == rt) ? wData : regs[rt];

endmodule
